/* arb_pkg.sv */
`default_nettype none

package arb_pkg;

    // lane number, 0 or 1.
    typedef logic lane_id_t;

    // grant of the packet merger.
    typedef enum logic [1:0] {
        idle       = 2'd0, // waiting for a packet boundary.
        lane0_busy = 2'd1, // lane 0 owns the output.
        lane1_busy = 2'd2  // lane 1 owns the output.
    } grant_state_t;

endpackage

`default_nettype wire

/* stream_pkg.sv */
`default_nettype none

package stream_pkg;

    parameter int DATA_WIDTH = 16; // default beat width.

    // one beat of a lane.
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic                  last; // final beat of a packet.
    } beat_t;

    // one beat of the merged output stream.
    typedef struct packed {
        arb_pkg::lane_id_t lane; // source lane.
        beat_t             beat;
    } tagged_beat_t;

endpackage

`default_nettype wire

/* stream_if.sv */
`timescale 1ns/1ps
`default_nettype none

// valid/ready stream link.
// a beat moves on a clock edge with tvalid and tready both high.
interface stream_if #(
    parameter int DATA_WIDTH = stream_pkg::DATA_WIDTH
) ();

    logic                  tvalid;
    logic                  tready;
    logic [DATA_WIDTH-1:0] tdata;
    logic                  tlast;

    // source side of the link.
    modport producer (
        output tvalid,
        output tdata,
        output tlast,
        input  tready
    );

    // sink side of the link.
    modport consumer (
        input  tvalid,
        input  tdata,
        input  tlast,
        output tready
    );

endinterface

`default_nettype wire

/* skid_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module skid_buffer #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  payload_t din,
    input  logic     din_valid,
    output logic     din_ready,
    output payload_t dout,
    output logic     dout_valid,
    input  logic     dout_ready
);

    payload_t spare;       // catches the beat in flight on a stall.
    logic     spare_valid;
    logic     load_main;
    logic     load_spare;

    // main register is free when empty or draining.
    assign load_main  = ~spare_valid & (~dout_valid | dout_ready);
    assign load_spare = ~spare_valid & dout_valid & ~dout_ready & din_valid;

    // ready comes from a flop only.
    assign din_ready = ~spare_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            dout_valid  <= 1'b0;
            spare_valid <= 1'b0;
        end else begin
            if (spare_valid) begin
                if (dout_ready) begin
                    spare_valid <= 1'b0; // spare moves up, main stays valid.
                end
            end else if (load_main) begin
                dout_valid <= din_valid;
            end else if (load_spare) begin
                spare_valid <= 1'b1;
            end
        end
    end

    // payload path.
    always_ff @(posedge clk) begin
        if (spare_valid & dout_ready) begin
            dout <= spare;
        end else if (load_main & din_valid) begin
            dout <= din;
        end
        if (load_spare) begin
            spare <= din;
        end
    end

endmodule

`default_nettype wire

/* simple_dual_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module simple_dual_ram #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 8
) (
    input  logic                     clk,
    input  logic                     wr_en,
    input  logic [$clog2(DEPTH)-1:0] wr_addr,
    input  payload_t                 wr_data,
    input  logic [$clog2(DEPTH)-1:0] rd_addr,
    output payload_t                 rd_data
);

    payload_t                 mem [DEPTH];
    logic [$clog2(DEPTH)-1:0] rd_addr_q; // first read stage.

    // write port.
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read port, address register then output register.
    // a same-edge write to the read slot returns the old word.
    always_ff @(posedge clk) begin
        rd_addr_q <= rd_addr;
        rd_data   <= mem[rd_addr_q];
    end

endmodule

`default_nettype wire

/* axis_fifo_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module axis_fifo_sync #(
    parameter int DATA_WIDTH = stream_pkg::DATA_WIDTH,
    parameter int ADDR_WIDTH = 3
) (
    input logic        clk,
    input logic        rst,
    stream_if.consumer wr,
    stream_if.producer rd
);

    typedef enum logic [1:0] {
        normal   = 2'd0,
        one_held = 2'd1,
        two_held = 2'd2
    } catch_state_t;

    stream_pkg::beat_t   wr_beat;
    stream_pkg::beat_t   wq_beat;  // out of the write skid buffer.
    logic                wq_valid;
    logic                wq_ready;
    logic [ADDR_WIDTH:0] wr_ptr;   // msb is the wrap bit.
    logic [ADDR_WIDTH:0] rd_ptr;
    logic                fifo_full;
    logic                fifo_empty;
    stream_pkg::beat_t   ram_beat;
    logic                rd_req;
    logic [1:0]          rd_pipe;  // tracks the two ram read stages.
    catch_state_t        state;
    catch_state_t        state_next;
    stream_pkg::beat_t   hold0;    // oldest held beat.
    stream_pkg::beat_t   hold1;
    stream_pkg::beat_t   rq_beat;  // into the read skid buffer.
    logic                rq_valid;
    logic                rq_ready;
    stream_pkg::beat_t   rd_beat;

    assign wr_beat.data = wr.tdata[DATA_WIDTH-1:0];
    assign wr_beat.last = wr.tlast;

    skid_buffer #(
        .payload_t(stream_pkg::beat_t)
    ) i_skid_wr (
        .clk        (clk),
        .rst        (rst),
        .din        (wr_beat),
        .din_valid  (wr.tvalid),
        .din_ready  (wr.tready),
        .dout       (wq_beat),
        .dout_valid (wq_valid),
        .dout_ready (wq_ready)
    );

    assign fifo_empty = (wr_ptr == rd_ptr);
    assign fifo_full  = (wr_ptr[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH]) &&
                        (wr_ptr[ADDR_WIDTH-1:0] == rd_ptr[ADDR_WIDTH-1:0]);
    assign wq_ready   = ~fifo_full;

    // new reads only start while nothing is held.
    assign rd_req = rq_ready & ~fifo_empty & (state == normal);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            rd_pipe <= 2'b00;
        end else begin
            if (wq_valid & wq_ready) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_req) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            rd_pipe <= {rd_pipe[0], rd_req};
        end
    end

    simple_dual_ram #(
        .payload_t (stream_pkg::beat_t),
        .DEPTH     (2**ADDR_WIDTH)
    ) i_ram (
        .clk     (clk),
        .wr_en   (wq_valid & wq_ready),
        .wr_addr (wr_ptr[ADDR_WIDTH-1:0]),
        .wr_data (wq_beat),
        .rd_addr (rd_ptr[ADDR_WIDTH-1:0]),
        .rd_data (ram_beat)
    );

    // catch-up FSM. up to two reads are in flight when the read side stalls.
    always_comb begin
        state_next = state;
        case (state)
            normal: begin
                if (rd_pipe[1] & ~rq_ready) state_next = one_held;
            end
            one_held: begin
                if (rq_ready) begin
                    if (!rd_pipe[1]) state_next = normal; // nothing more arriving.
                end else if (rd_pipe[1]) begin
                    state_next = two_held;
                end
            end
            two_held: begin
                if (rq_ready) state_next = one_held;
            end
            default: state_next = normal;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= normal;
        end else begin
            state <= state_next;
        end
    end

    // held beats keep their arrival order.
    always_ff @(posedge clk) begin
        case (state)
            normal: begin
                if (rd_pipe[1] & ~rq_ready) hold0 <= ram_beat;
            end
            one_held: begin
                if (rd_pipe[1]) begin
                    if (rq_ready) hold0 <= ram_beat;
                    else hold1 <= ram_beat;
                end
            end
            two_held: begin
                if (rq_ready) hold0 <= hold1; // second beat moves up.
            end
            default: ;
        endcase
    end

    assign rq_beat  = (state == normal) ? ram_beat : hold0;
    assign rq_valid = rd_pipe[1] | (state != normal);

    skid_buffer #(
        .payload_t(stream_pkg::beat_t)
    ) i_skid_rd (
        .clk        (clk),
        .rst        (rst),
        .din        (rq_beat),
        .din_valid  (rq_valid),
        .din_ready  (rq_ready),
        .dout       (rd_beat),
        .dout_valid (rd.tvalid),
        .dout_ready (rd.tready)
    );

    assign rd.tdata = DATA_WIDTH'(rd_beat.data);
    assign rd.tlast = rd_beat.last;

endmodule

`default_nettype wire

/* packet_merger.sv */
`timescale 1ns/1ps
`default_nettype none

module packet_merger #(
    parameter int DATA_WIDTH = stream_pkg::DATA_WIDTH
) (
    input  logic                  clk,
    input  logic                  rst,
    stream_if.consumer            lane0,
    stream_if.consumer            lane1,
    output logic [DATA_WIDTH-1:0] out_tdata,
    output logic                  out_tlast,
    output arb_pkg::lane_id_t     out_tlane,
    output logic                  out_tvalid,
    input  logic                  out_tready
);

    arb_pkg::grant_state_t    state;
    arb_pkg::grant_state_t    state_next;
    arb_pkg::lane_id_t        last_lane; // sender of the previous packet.
    arb_pkg::lane_id_t        pick;
    arb_pkg::lane_id_t        cur_lane;
    stream_pkg::tagged_beat_t in_beat;
    logic                     in_valid;
    logic                     in_ready;
    logic                     in_fire;
    stream_pkg::tagged_beat_t out_beat;

    // round-robin choice at a packet boundary.
    always_comb begin
        if (lane0.tvalid & lane1.tvalid) begin
            pick = ~last_lane; // the other lane wins a tie.
        end else if (lane1.tvalid) begin
            pick = 1'b1;
        end else begin
            pick = 1'b0;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            arb_pkg::idle: begin
                if (lane0.tvalid | lane1.tvalid) begin
                    if (pick) state_next = arb_pkg::lane1_busy;
                    else state_next = arb_pkg::lane0_busy;
                end
            end
            arb_pkg::lane0_busy, arb_pkg::lane1_busy: begin
                if (in_fire & in_beat.beat.last) state_next = arb_pkg::idle;
            end
            default: state_next = arb_pkg::idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= arb_pkg::idle;
            last_lane <= 1'b1; // lane 0 goes first.
        end else begin
            state <= state_next;
            if (in_fire & in_beat.beat.last) begin
                last_lane <= cur_lane;
            end
        end
    end

    assign cur_lane = (state == arb_pkg::lane1_busy);

    // only the granted lane sees ready.
    assign lane0.tready = (state == arb_pkg::lane0_busy) & in_ready;
    assign lane1.tready = (state == arb_pkg::lane1_busy) & in_ready;

    assign in_valid = ((state == arb_pkg::lane0_busy) & lane0.tvalid) |
                      ((state == arb_pkg::lane1_busy) & lane1.tvalid);
    assign in_fire  = in_valid & in_ready;

    assign in_beat.lane      = cur_lane;
    assign in_beat.beat.data = cur_lane ? lane1.tdata : lane0.tdata;
    assign in_beat.beat.last = cur_lane ? lane1.tlast : lane0.tlast;

    skid_buffer #(
        .payload_t(stream_pkg::tagged_beat_t)
    ) i_skid_out (
        .clk        (clk),
        .rst        (rst),
        .din        (in_beat),
        .din_valid  (in_valid),
        .din_ready  (in_ready),
        .dout       (out_beat),
        .dout_valid (out_tvalid),
        .dout_ready (out_tready)
    );

    assign out_tdata = DATA_WIDTH'(out_beat.beat.data);
    assign out_tlast = out_beat.beat.last;
    assign out_tlane = out_beat.lane;

endmodule

`default_nettype wire

/* stream_merge_top.sv */
`timescale 1ns/1ps
`default_nettype none

module stream_merge_top #(
    parameter int DATA_WIDTH = stream_pkg::DATA_WIDTH,
    parameter int ADDR_WIDTH = 3
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [DATA_WIDTH-1:0] in0_tdata,
    input  logic                  in0_tlast,
    input  logic                  in0_tvalid,
    output logic                  in0_tready,
    input  logic [DATA_WIDTH-1:0] in1_tdata,
    input  logic                  in1_tlast,
    input  logic                  in1_tvalid,
    output logic                  in1_tready,
    output logic [DATA_WIDTH-1:0] out_tdata,
    output logic                  out_tlast,
    output arb_pkg::lane_id_t     out_tlane,
    output logic                  out_tvalid,
    input  logic                  out_tready
);

    stream_if #(.DATA_WIDTH(DATA_WIDTH)) in0_if ();
    stream_if #(.DATA_WIDTH(DATA_WIDTH)) in1_if ();
    stream_if #(.DATA_WIDTH(DATA_WIDTH)) lane0_if (); // fifo 0 to merger.
    stream_if #(.DATA_WIDTH(DATA_WIDTH)) lane1_if (); // fifo 1 to merger.

    assign in0_if.tdata  = in0_tdata;
    assign in0_if.tlast  = in0_tlast;
    assign in0_if.tvalid = in0_tvalid;
    assign in0_tready    = in0_if.tready;

    assign in1_if.tdata  = in1_tdata;
    assign in1_if.tlast  = in1_tlast;
    assign in1_if.tvalid = in1_tvalid;
    assign in1_tready    = in1_if.tready;

    axis_fifo_sync #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) i_fifo0 (
        .clk (clk),
        .rst (rst),
        .wr  (in0_if),
        .rd  (lane0_if)
    );

    axis_fifo_sync #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) i_fifo1 (
        .clk (clk),
        .rst (rst),
        .wr  (in1_if),
        .rd  (lane1_if)
    );

    packet_merger #(
        .DATA_WIDTH (DATA_WIDTH)
    ) i_merger (
        .clk        (clk),
        .rst        (rst),
        .lane0      (lane0_if),
        .lane1      (lane1_if),
        .out_tdata  (out_tdata),
        .out_tlast  (out_tlast),
        .out_tlane  (out_tlane),
        .out_tvalid (out_tvalid),
        .out_tready (out_tready)
    );

endmodule

`default_nettype wire

/* stream_merge_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module stream_merge_properties #(
    parameter int DATA_WIDTH = stream_pkg::DATA_WIDTH
) (
    input logic                  clk,
    input logic                  rst,
    input logic [DATA_WIDTH-1:0] out_tdata,
    input logic                  out_tlast,
    input arb_pkg::lane_id_t     out_tlane,
    input logic                  out_tvalid,
    input logic                  out_tready
);

    arb_pkg::grant_state_t pkt_state; // lane of the packet now leaving.

    always_ff @(posedge clk) begin
        if (rst) begin
            pkt_state <= arb_pkg::idle;
        end else if (out_tvalid & out_tready) begin
            if (out_tlast) pkt_state <= arb_pkg::idle;
            else if (out_tlane) pkt_state <= arb_pkg::lane1_busy;
            else pkt_state <= arb_pkg::lane0_busy;
        end
    end

    valid_held: assert property (@(posedge clk) disable iff (rst)
        out_tvalid && !out_tready |=> out_tvalid)
        else $error("out_tvalid dropped before its transfer");

    payload_stable: assert property (@(posedge clk) disable iff (rst)
        out_tvalid && !out_tready |=> $stable(out_tdata) && $stable(out_tlast))
        else $error("out payload changed while stalled");

    idle_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !out_tvalid)
        else $error("out_tvalid high right after reset");

    lane_kept: assert property (@(posedge clk) disable iff (rst)
        out_tvalid && pkt_state != arb_pkg::idle |->
            out_tlane == (pkt_state == arb_pkg::lane1_busy))
        else $error("out_tlane changed inside a packet");

endmodule

bind stream_merge_top stream_merge_properties #(
    .DATA_WIDTH (DATA_WIDTH)
) i_properties (
    .clk        (clk),
    .rst        (rst),
    .out_tdata  (out_tdata),
    .out_tlast  (out_tlast),
    .out_tlane  (out_tlane),
    .out_tvalid (out_tvalid),
    .out_tready (out_tready)
);

`default_nettype wire

/* stream_merge_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module stream_merge_tb;

    localparam int DATA_WIDTH = stream_pkg::DATA_WIDTH;
    localparam int ADDR_WIDTH = 3;
    localparam int NUM_PKTS   = 15;
    localparam logic [31:0] SEED = 32'd10919;

    // one packet of stimulus with data counting up from start.
    typedef struct packed {
        arb_pkg::lane_id_t     lane;
        logic [7:0]            len;
        logic [DATA_WIDTH-1:0] start;
    } packet_t;

    // 0..5 round-robin, 6 fills lane 0, 7..14 random traffic.
    localparam packet_t PACKETS [NUM_PKTS] = '{
        '{1'b0, 8'd3,  16'h0100}, '{1'b1, 8'd2, 16'h1100}, '{1'b0, 8'd1, 16'h0200},
        '{1'b1, 8'd4,  16'h1200}, '{1'b0, 8'd2, 16'h0300}, '{1'b1, 8'd3, 16'h1300},
        '{1'b0, 8'd24, 16'h0400},
        '{1'b1, 8'd5,  16'h1400}, '{1'b0, 8'd4, 16'h0500}, '{1'b0, 8'd7, 16'h0600},
        '{1'b1, 8'd1,  16'h1500}, '{1'b1, 8'd6, 16'h1600}, '{1'b0, 8'd3, 16'h0700},
        '{1'b1, 8'd8,  16'h1700}, '{1'b0, 8'd1, 16'h0800}
    };

    logic                  clk;
    logic                  rst;
    logic [DATA_WIDTH-1:0] in0_tdata;
    logic                  in0_tlast;
    logic                  in0_tvalid;
    logic                  in0_tready;
    logic [DATA_WIDTH-1:0] in1_tdata;
    logic                  in1_tlast;
    logic                  in1_tvalid;
    logic                  in1_tready;
    logic [DATA_WIDTH-1:0] out_tdata;
    logic                  out_tlast;
    arb_pkg::lane_id_t     out_tlane;
    logic                  out_tvalid;
    logic                  out_tready;

    stream_pkg::beat_t exp_q0 [$]; // per-lane scoreboard.
    stream_pkg::beat_t exp_q1 [$];
    arb_pkg::lane_id_t lane_order [$]; // lane of each finished packet.
    stream_pkg::beat_t exp_beat;
    logic              in_pkt;
    arb_pkg::lane_id_t pkt_lane;
    logic [31:0]       rng_lane [2];
    logic [31:0]       rng_ready;
    logic [1:0]        ready_mode; // 0 stall, 1 ready, 2 random.
    int                cycle_count = 0;
    int                cycle_limit;

    stream_merge_top #(
        .DATA_WIDTH (DATA_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) i_stream_merge_top (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic gap_now(input int lane);
        rng_lane[lane] = xorshift32(rng_lane[lane]);
        return rng_lane[lane][1:0] == 2'b00; // idle about one cycle in four.
    endfunction

    function automatic logic lane_ready(input int lane);
        return (lane == 0) ? in0_tready : in1_tready;
    endfunction

    task automatic stop_on_failure(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            stop_on_failure($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic set_lane(input int lane, input logic valid, input stream_pkg::beat_t beat);
        if (lane == 0) begin
            in0_tvalid <= valid;
            in0_tdata  <= beat.data;
            in0_tlast  <= beat.last;
        end else begin
            in1_tvalid <= valid;
            in1_tdata  <= beat.data;
            in1_tlast  <= beat.last;
        end
    endtask

    // sends the table packets of one lane from just after a rising edge.
    task automatic drive_lane(input int lane, input int first_pkt, input int end_pkt,
                              input bit gaps);
        stream_pkg::beat_t beat;
        int p;
        int n;
        for (p = first_pkt; p <= end_pkt; p++) begin
            if (int'(PACKETS[p].lane) == lane) begin
                for (n = 0; n < int'(PACKETS[p].len); n++) begin
                    while (gaps && gap_now(lane)) begin
                        set_lane(lane, 1'b0, '0);
                        @(posedge clk);
                    end
                    beat.data = PACKETS[p].start + DATA_WIDTH'(n);
                    beat.last = (n == int'(PACKETS[p].len) - 1);
                    set_lane(lane, 1'b1, beat);
                    do begin
                        @(posedge clk);
                    end while (!lane_ready(lane));
                    if (lane == 0) exp_q0.push_back(beat);
                    else exp_q1.push_back(beat);
                end
            end
        end
        set_lane(lane, 1'b0, '0);
    endtask

    task automatic wait_drained();
        @(negedge clk);
        while (exp_q0.size() != 0 || exp_q1.size() != 0) @(negedge clk);
        @(posedge clk);
    endtask

    always @(posedge clk) begin
        rng_ready = xorshift32(rng_ready);
        case (ready_mode)
            2'd0: out_tready <= 1'b0;
            2'd1: out_tready <= 1'b1;
            default: out_tready <= rng_ready[3];
        endcase
    end

    // output monitor.
    always @(posedge clk) begin
        if (!rst && out_tvalid && out_tready) begin
            if (out_tlane == 1'b0 && exp_q0.size() == 0) begin
                stop_on_failure("output beat on lane 0 while no lane 0 beat was expected");
            end else if (out_tlane == 1'b1 && exp_q1.size() == 0) begin
                stop_on_failure("output beat on lane 1 while no lane 1 beat was expected");
            end else begin
                exp_beat = out_tlane ? exp_q1.pop_front() : exp_q0.pop_front();
                check_value("out_tdata", 32'(out_tdata), 32'(exp_beat.data));
                check_value("out_tlast", 32'(out_tlast), 32'(exp_beat.last));
                if (in_pkt) check_value("out_tlane", 32'(out_tlane), 32'(pkt_lane));
                in_pkt   = ~out_tlast;
                pkt_lane = out_tlane;
                if (out_tlast) lane_order.push_back(out_tlane);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == cycle_limit) begin
            stop_on_failure($sformatf("timeout, run still busy after %0d cycles", cycle_limit));
        end
    end

    initial begin
        int i;
        int total;
        total = 0;
        for (i = 0; i < NUM_PKTS; i++) total += int'(PACKETS[i].len);
        cycle_limit   = 20 * total + 200;
        rng_lane[0]   = xorshift32(SEED);
        rng_lane[1]   = xorshift32(rng_lane[0]);
        rng_ready     = xorshift32(rng_lane[1]);
        clk           = 1'b0;
        rst           = 1'b1;
        in0_tdata     = '0;
        in0_tlast     = 1'b0;
        in0_tvalid    = 1'b0;
        in1_tdata     = '0;
        in1_tlast     = 1'b0;
        in1_tvalid    = 1'b0;
        out_tready    = 1'b0;
        ready_mode    = 2'd0;
        in_pkt        = 1'b0;
        pkt_lane      = 1'b0;

        @(posedge clk);
        repeat (3) begin
            @(negedge clk);
            check_value("out_tvalid", 32'(out_tvalid), 32'd0);
            @(posedge clk);
        end
        rst <= 1'b0;
        @(negedge clk);
        check_value("out_tvalid", 32'(out_tvalid), 32'd0);
        check_value("in0_tready", 32'(in0_tready), 32'd1);
        check_value("in1_tready", 32'(in1_tready), 32'd1);
        @(posedge clk);

        // both lanes start together and six packets queue up behind a stalled output.
        fork
            drive_lane(0, 0, 5, 1'b0);
            drive_lane(1, 0, 5, 1'b0);
        join
        ready_mode <= 2'd1;
        wait_drained();
        for (i = 0; i < 6; i++) check_value("out_tlane", 32'(lane_order[i]), 32'(i % 2));

        // long packet on lane 0 until its input stalls.
        ready_mode <= 2'd0;
        fork
            drive_lane(0, 6, 6, 1'b0);
            begin
                while (in0_tready) @(posedge clk);
                ready_mode <= 2'd2;
                while (!in0_tready) @(posedge clk);
            end
        join
        wait_drained();

        fork
            drive_lane(0, 7, NUM_PKTS - 1, 1'b1);
            drive_lane(1, 7, NUM_PKTS - 1, 1'b1);
        join
        wait_drained();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
arb_pkg.sv
stream_pkg.sv
stream_if.sv
skid_buffer.sv
simple_dual_ram.sv
axis_fifo_sync.sv
packet_merger.sv
stream_merge_top.sv
stream_merge_properties.sv
stream_merge_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= stream_merge_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Simulation finished: PASS

.PHONY: sim clean

# build, run, and fail unless the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
